//--- hdl/soc_types_pkg.sv
`default_nettype none

package soc_types_pkg;

   // Wishbone geometry, byte addressed
   localparam int WB_AW = 16;
   localparam int WB_DW = 32;

   typedef logic [WB_AW-1:0] wb_adr_t;
   typedef logic [WB_DW-1:0] wb_dat_t;

   // Settings bus, one register write per strobe
   typedef logic [7:0] set_addr_t;

   typedef struct packed {
      logic        stb;
      set_addr_t   addr;
      logic [31:0] data;
   } set_bus_t;

   typedef logic [63:0] vita_time_t;

endpackage

`default_nettype wire

//--- hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

   // Top address byte decode, region start and mask
   localparam logic [7:0] RB_ADDR  = 8'h5C;
   localparam logic [7:0] RB_MASK  = 8'hFC;
   localparam logic [7:0] SET_ADDR = 8'h70;
   localparam logic [7:0] SET_MASK = 8'hF0;

   // Misc settings block and its register offsets
   localparam int SR_MISC   = 0;
   localparam int LMS_RES   = 0;
   localparam int LED_SW    = 3;
   localparam int PHY_RST   = 4;
   localparam int BLDR_DONE = 5;
   localparam int LED_SRC   = 6;

   // Time load registers
   localparam int SR_TIME64 = 10;
   localparam int TIME_HI   = 0;
   localparam int TIME_LO   = 1;

   // Diversity switches, one bit each
   localparam int SR_DIVSW  = 180;
   localparam int DIVSW_0   = 0;
   localparam int DIVSW_1   = 1;

   // LEDs 4..1 follow the run bits out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   // Major in the upper half, minor in the lower
   localparam logic [31:0] COMPAT_NUM = {16'd9, 16'd0};

   // Readback word indexes
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_STATUS  = 4'd13;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

endpackage

`default_nettype wire

//--- hdl/wb_slave_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded Wishbone slave channel
interface wb_slave_if #(
   parameter int AW = 16,
   parameter int DW = 32
);
   logic          stb;
   logic          we;
   logic [AW-1:0] adr;
   logic [DW-1:0] dat_w;
   logic [DW-1:0] dat_r;
   logic          ack;

   modport master (output stb, we, adr, dat_w, input dat_r, ack);
   modport slave (input stb, we, adr, dat_w, output dat_r, ack);
endinterface

`default_nettype wire

//--- hdl/wb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decoder
   import soc_types_pkg::*, soc_map_pkg::*;
(
   input  wire         wb_clk,
   input  wire         rst_i,
   input  wire         stb_i,
   input  wire         we_i,
   input  wb_adr_t     adr_i,
   input  wb_dat_t     dat_i,
   output wb_dat_t     dat_o,
   output logic        ack_o,
   wb_slave_if.master  set_m,
   wb_slave_if.master  rb_m
);

   logic set_hit;
   logic rb_hit;
   logic nomatch_ack;

   assign set_hit = (adr_i[15:8] & SET_MASK) == SET_ADDR;
   assign rb_hit  = (adr_i[15:8] & RB_MASK) == RB_ADDR;

   // Only the matching slave sees the strobe
   assign set_m.stb   = stb_i & set_hit;
   assign set_m.we    = we_i;
   assign set_m.adr   = adr_i;
   assign set_m.dat_w = dat_i;

   assign rb_m.stb   = stb_i & rb_hit;
   assign rb_m.we    = we_i;
   assign rb_m.adr   = adr_i;
   assign rb_m.dat_w = dat_i;

   // Unmapped accesses complete here so the master never hangs
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         nomatch_ack <= 1'b0;
      end else begin
         nomatch_ack <= stb_i & ~set_hit & ~rb_hit & ~nomatch_ack;
      end
   end

   assign ack_o = set_m.ack | rb_m.ack | nomatch_ack;
   assign dat_o = rb_hit ? rb_m.dat_r : (set_hit ? set_m.dat_r : '0);

   a_one_slave: assert property (@(posedge wb_clk) disable iff (rst_i)
      !(set_m.stb && rb_m.stb));

endmodule

`default_nettype wire

//--- hdl/settings_bus.sv
`timescale 1ns/1ps
`default_nettype none

module settings_bus
   import soc_types_pkg::*;
(
   input  wire        wb_clk,
   input  wire        rst_i,
   wb_slave_if.slave  bus_s,
   output set_bus_t   set_o
);

   logic        ack;
   logic        set_stb;
   set_addr_t   set_addr;
   logic [31:0] set_data;

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack     <= 1'b0;
         set_stb <= 1'b0;
      end else begin
         ack     <= bus_s.stb & ~ack;
         set_stb <= bus_s.stb & bus_s.we & ~ack;
      end
   end

   // Word address picks one of 256 registers
   always_ff @(posedge wb_clk) begin
      if (bus_s.stb && !ack) begin
         set_addr <= bus_s.adr[9:2];
         set_data <= bus_s.dat_w;
      end
   end

   assign bus_s.ack   = ack;
   assign bus_s.dat_r = '0;
   assign set_o       = '{stb: set_stb, addr: set_addr, data: set_data};

   a_ack_pulse: assert property (@(posedge wb_clk) disable iff (rst_i)
      bus_s.ack |=> !bus_s.ack);
   a_stb_pulse: assert property (@(posedge wb_clk) disable iff (rst_i)
      set_o.stb |-> bus_s.ack ##1 !set_o.stb);

endmodule

`default_nettype wire

//--- hdl/misc_settings.sv
`timescale 1ns/1ps
`default_nettype none

module misc_settings
   import soc_types_pkg::*, soc_map_pkg::*;
#(
   parameter int MISC_BASE  = SR_MISC,
   parameter int DIVSW_BASE = SR_DIVSW
) (
   input  wire        wb_clk,
   input  wire        por_rst,
   input  set_bus_t   set_i,
   input  wire  [3:0] run_i,
   output logic       core_rst_o,
   output logic [7:0] leds_o,
   output logic [1:0] lms_res_o,
   output logic       phy_reset_n_o,
   output logic [1:0] div_sw_o
);

   localparam set_addr_t A_LMS_RES = set_addr_t'(MISC_BASE + LMS_RES);
   localparam set_addr_t A_LED_SW  = set_addr_t'(MISC_BASE + LED_SW);
   localparam set_addr_t A_PHY_RST = set_addr_t'(MISC_BASE + PHY_RST);
   localparam set_addr_t A_BLDR    = set_addr_t'(MISC_BASE + BLDR_DONE);
   localparam set_addr_t A_LED_SRC = set_addr_t'(MISC_BASE + LED_SRC);
   localparam set_addr_t A_DIVSW_0 = set_addr_t'(DIVSW_BASE + DIVSW_0);
   localparam set_addr_t A_DIVSW_1 = set_addr_t'(DIVSW_BASE + DIVSW_1);

   typedef enum logic {BLDR_WAIT, BLDR_DONE_ST} bldr_state_t;

   bldr_state_t bldr_state;
   logic        bldr_wr;
   logic [1:0]  lms_res;
   logic [7:0]  led_sw;
   logic        phy_rst;
   logic [7:0]  led_src;
   logic [1:0]  div_sw;
   logic [7:0]  led_hw;

   //////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge wb_clk) begin
      if (por_rst || core_rst_o) begin
         lms_res <= '0;
         led_sw  <= '0;
         phy_rst <= 1'b0;
         led_src <= LED_SRC_RESET;
         div_sw  <= 2'b11;
      end else if (set_i.stb) begin
         case (set_i.addr)
            A_LMS_RES: lms_res   <= set_i.data[1:0];
            A_LED_SW:  led_sw    <= set_i.data[7:0];
            A_PHY_RST: phy_rst   <= set_i.data[0];
            A_LED_SRC: led_src   <= set_i.data[7:0];
            A_DIVSW_0: div_sw[0] <= set_i.data[0];
            A_DIVSW_1: div_sw[1] <= set_i.data[0];
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Boot soft reset

   assign bldr_wr = set_i.stb && (set_i.addr == A_BLDR) && set_i.data[0];

   // Held through power-on, then one pulse when boot reports done
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         bldr_state <= BLDR_WAIT;
         core_rst_o <= 1'b1;
      end else begin
         core_rst_o <= 1'b0;
         if (bldr_state == BLDR_WAIT && bldr_wr) begin
            bldr_state <= BLDR_DONE_ST;
            core_rst_o <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Outputs

   // Mask bit 1 selects hardware, 0 selects software
   assign led_hw        = {3'b000, run_i, 1'b0};
   assign leds_o        = (led_src & led_hw) | (~led_src & led_sw);
   assign lms_res_o     = lms_res;
   assign phy_reset_n_o = ~phy_rst;
   assign div_sw_o      = div_sw;

endmodule

`default_nettype wire

//--- hdl/vita_timer.sv
`timescale 1ns/1ps
`default_nettype none

module vita_timer
   import soc_types_pkg::*, soc_map_pkg::*;
#(
   parameter int TIME_BASE = SR_TIME64
) (
   input  wire        wb_clk,
   input  wire        rst_i,
   input  set_bus_t   set_i,
   input  wire        pps_i,
   output vita_time_t time_o,
   output vita_time_t time_pps_o
);

   localparam set_addr_t A_TIME_HI = set_addr_t'(TIME_BASE + TIME_HI);
   localparam set_addr_t A_TIME_LO = set_addr_t'(TIME_BASE + TIME_LO);

   logic [31:0] hi_stage;
   logic [1:0]  pps_sync;
   logic        pps_d;
   logic        pps_edge;

   // High word waits here until the low word arrives
   always_ff @(posedge wb_clk) begin
      if (set_i.stb && set_i.addr == A_TIME_HI) begin
         hi_stage <= set_i.data;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         time_o <= '0;
      end else if (set_i.stb && set_i.addr == A_TIME_LO) begin
         time_o <= {hi_stage, set_i.data};
      end else begin
         time_o <= time_o + 64'd1;
      end
   end

   //////////////////////////////////////////////////
   // PPS capture

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_d;

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         time_pps_o <= '0;
      end else if (pps_edge) begin
         time_pps_o <= time_o;
      end
   end

endmodule

`default_nettype wire

//--- hdl/readback_mux.sv
`timescale 1ns/1ps
`default_nettype none

module readback_mux
   import soc_types_pkg::*, soc_map_pkg::*;
(
   input  wire         wb_clk,
   input  wire         rst_i,
   wb_slave_if.slave   bus_s,
   input  vita_time_t  time_i,
   input  vita_time_t  time_pps_i,
   input  wire  [31:0] status_i
);

   logic    ack;
   wb_dat_t rd_word;
   wb_dat_t rd_data;

   always_comb begin
      case (bus_s.adr[5:2])
         RB_TIME_HI: rd_word = time_i[63:32];
         RB_TIME_LO: rd_word = time_i[31:0];
         RB_COMPAT:  rd_word = COMPAT_NUM;
         RB_STATUS:  rd_word = status_i;
         RB_PPS_HI:  rd_word = time_pps_i[63:32];
         RB_PPS_LO:  rd_word = time_pps_i[31:0];
         default:    rd_word = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack <= 1'b0;
      end else begin
         ack <= bus_s.stb & ~ack;
      end
   end

   // Word is sampled on the first strobe cycle and held for the ack
   always_ff @(posedge wb_clk) begin
      if (bus_s.stb && !ack) begin
         rd_data <= rd_word;
      end
   end

   assign bus_s.ack   = ack;
   assign bus_s.dat_r = rd_data;

   a_no_back_to_back: assert property (@(posedge wb_clk) disable iff (rst_i)
      bus_s.ack |=> !bus_s.ack);

endmodule

`default_nettype wire

//--- hdl/soc_core.sv
`timescale 1ns/1ps
`default_nettype none

module soc_core
   import soc_types_pkg::*, soc_map_pkg::*;
#(
   parameter int MISC_BASE  = SR_MISC,
   parameter int DIVSW_BASE = SR_DIVSW,
   parameter int TIME_BASE  = SR_TIME64
) (
   input  wire        wb_clk,
   input  wire        por_rst,
   input  wire        wb_stb_i,
   input  wire        wb_we_i,
   input  wb_adr_t    wb_adr_i,
   input  wb_dat_t    wb_dat_i,
   input  wire        pps_i,
   input  wire  [3:0] run_i,
   input  wire        button_i,
   input  wire  [1:0] lock_det_i,
   output wb_dat_t    wb_dat_o,
   output logic       wb_ack_o,
   output logic [7:0] leds_o,
   output logic [1:0] lms_res_o,
   output logic       phy_reset_n_o,
   output logic [1:0] div_sw_o
);

   logic       core_rst;
   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   wb_slave_if #(.AW(WB_AW), .DW(WB_DW)) set_if ();
   wb_slave_if #(.AW(WB_AW), .DW(WB_DW)) rb_if ();

   //////////////////////////////////////////////////
   // Wishbone fabric

   wb_decoder u_decoder (
      .wb_clk (wb_clk),
      .rst_i  (por_rst),
      .stb_i  (wb_stb_i),
      .we_i   (wb_we_i),
      .adr_i  (wb_adr_i),
      .dat_i  (wb_dat_i),
      .dat_o  (wb_dat_o),
      .ack_o  (wb_ack_o),
      .set_m  (set_if),
      .rb_m   (rb_if)
   );

   settings_bus u_settings_bus (
      .wb_clk (wb_clk),
      .rst_i  (core_rst),
      .bus_s  (set_if),
      .set_o  (set_bus)
   );

   // Status word carries the lock detects and the button
   readback_mux u_readback (
      .wb_clk     (wb_clk),
      .rst_i      (core_rst),
      .bus_s      (rb_if),
      .time_i     (vita_time),
      .time_pps_i (vita_time_pps),
      .status_i   ({16'b0, lock_det_i, button_i, 13'b0})
   );

   //////////////////////////////////////////////////
   // Settings consumers

   misc_settings #(
      .MISC_BASE  (MISC_BASE),
      .DIVSW_BASE (DIVSW_BASE)
   ) u_misc (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .set_i         (set_bus),
      .run_i         (run_i),
      .core_rst_o    (core_rst),
      .leds_o        (leds_o),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .div_sw_o      (div_sw_o)
   );

   vita_timer #(
      .TIME_BASE (TIME_BASE)
   ) u_timer (
      .wb_clk     (wb_clk),
      .rst_i      (core_rst),
      .set_i      (set_bus),
      .pps_i      (pps_i),
      .time_o     (vita_time),
      .time_pps_o (vita_time_pps)
   );

endmodule

`default_nettype wire

//--- tb/tb_soc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_core;

   // Settings addresses used by the random LED test
   localparam logic [15:0] LED_SW_ADR  = 16'h700C;
   localparam logic [15:0] LED_SRC_ADR = 16'h7018;

   logic        wb_clk;
   logic        por_rst;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        pps_i;
   logic [3:0]  run_i;
   logic        button_i;
   logic [1:0]  lock_det_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic [7:0]  leds_o;
   logic [1:0]  lms_res_o;
   logic        phy_reset_n_o;
   logic [1:0]  div_sw_o;

   logic [7:0]  op_list[$];
   logic [31:0] a_list[$];
   logic [31:0] b_list[$];
   logic [31:0] lfsr_state;
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;

   soc_core dut0 (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .pps_i         (pps_i),
      .run_i         (run_i),
      .button_i      (button_i),
      .lock_det_i    (lock_det_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .leds_o        (leds_o),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .div_sw_o      (div_sw_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   // Run limit, armed once the test file is loaded
   always @(posedge wb_clk) begin
      if (cycle_limit > 0) begin
         cycles <= cycles + 1;
         if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
         end
      end
   end

   //////////////////////////////////////////////////
   // Random values and expected LEDs

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h80200003;
      end
      return n;
   endfunction

   task automatic draw_bits(input int nbits, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Mask bit set takes the run bit, clear takes the software bit
   function automatic logic [7:0] led_rule(input logic [7:0] sw, input logic [7:0] src,
                                           input logic [3:0] run);
      logic [7:0] hw;
      logic [7:0] result;
      hw = 8'h00;
      for (int i = 0; i < 4; i++) begin
         hw[i + 1] = run[i];
      end
      for (int i = 0; i < 8; i++) begin
         result[i] = src[i] ? hw[i] : sw[i];
      end
      return result;
   endfunction

   //////////////////////////////////////////////////
   // Bus and pin operations

   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat, output logic acked);
      int waited;
      waited = 0;
      acked = 1'b0;
      rdat = '0;
      @(posedge wb_clk);
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      while (!acked && waited < 4) begin
         @(posedge wb_clk);
         waited++;
         if (wb_ack_o) begin
            acked = 1'b1;
            rdat = wb_dat_o;
         end
      end
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      if (!acked) begin
         errors++;
         $display("No ack within 4 cycles for the access to address %h", adr);
      end
   endtask

   task automatic read_check(input logic [15:0] adr, input logic [31:0] want);
      logic [31:0] got;
      logic        acked;
      bus_access(1'b0, adr, 32'h0, got, acked);
      checks++;
      if (acked && got !== want) begin
         errors++;
         $display("ERR %0t: read of %h returned %h, expected %h", $time, adr, got, want);
      end
   endtask

   task automatic check_pin(input logic [31:0] sel, input logic [31:0] want);
      logic [31:0] got;
      @(posedge wb_clk);
      case (sel)
         32'd0:   got = {30'b0, lms_res_o};
         32'd1:   got = {31'b0, phy_reset_n_o};
         32'd2:   got = {30'b0, div_sw_o};
         default: got = {24'b0, leds_o};
      endcase
      checks++;
      if (got !== want) begin
         errors++;
         $display("ERR %0t: pin group %0d is %h, expected %h", $time, sel, got, want);
      end
   endtask

   // Snapshot lands 3 cycles after the rise
   task automatic pulse_pps();
      @(posedge wb_clk);
      pps_i <= 1'b1;
      repeat (4) @(posedge wb_clk);
      pps_i <= 1'b0;
      repeat (4) @(posedge wb_clk);
   endtask

   task automatic set_inputs(input logic [31:0] run, input logic [31:0] btn_lock);
      @(posedge wb_clk);
      run_i      <= run[3:0];
      button_i   <= btn_lock[0];
      lock_det_i <= btn_lock[2:1];
   endtask

   task automatic led_random(input int count);
      logic [31:0] sw;
      logic [31:0] src;
      logic [31:0] run;
      logic [31:0] unused_rd;
      logic        acked;
      for (int n = 0; n < count; n++) begin
         draw_bits(8, sw);
         draw_bits(8, src);
         draw_bits(4, run);
         @(posedge wb_clk);
         run_i <= run[3:0];
         bus_access(1'b1, LED_SW_ADR, sw, unused_rd, acked);
         bus_access(1'b1, LED_SRC_ADR, src, unused_rd, acked);
         check_pin(32'd3, {24'b0, led_rule(sw[7:0], src[7:0], run[3:0])});
      end
   endtask

   //////////////////////////////////////////////////
   // Test file and main sequence

   task automatic load_tests();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("tb/soc_core_tests.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", op, a, b);
            if (n == 3 && op != "#") begin
               op_list.push_back(op);
               a_list.push_back(a);
               b_list.push_back(b);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic run_tests();
      logic [31:0] unused_rd;
      logic        acked;
      for (int i = 0; i < op_list.size(); i++) begin
         case (op_list[i])
            "W": bus_access(1'b1, a_list[i][15:0], b_list[i], unused_rd, acked);
            "R": read_check(a_list[i][15:0], b_list[i]);
            "P": pulse_pps();
            "I": set_inputs(a_list[i], b_list[i]);
            "C": check_pin(a_list[i], b_list[i]);
            "L": led_random(a_list[i]);
            default: begin
               errors++;
               $display("Unknown operation on test line %0d", i);
            end
         endcase
      end
   endtask

   initial begin
      por_rst     = 1'b1;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      pps_i       = 1'b0;
      run_i       = '0;
      button_i    = 1'b0;
      lock_det_i  = '0;
      lfsr_state  = 32'd78426;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      cycle_limit = 0;
      load_tests();
      if (op_list.size() == 0) begin
         $display("Could not read any operation from tb/soc_core_tests.txt");
         $display("*** FAILED ***");
         $finish;
      end else begin
         cycle_limit = op_list.size() * 20 + 100;
         repeat (8) @(posedge wb_clk);
         por_rst <= 1'b0;
         // Let the power-on soft reset drop
         repeat (2) @(posedge wb_clk);
         run_tests();
         $display("checks %0d errors %0d", checks, errors);
         if (errors == 0) begin
            $display("*** PASSED ***");
         end else begin
            $display("*** FAILED ***");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- list.f
hdl/soc_types_pkg.sv
hdl/soc_map_pkg.sv
hdl/wb_slave_if.sv
hdl/wb_decoder.sv
hdl/settings_bus.sv
hdl/misc_settings.sv
hdl/vita_timer.sv
hdl/readback_mux.sv
hdl/soc_core.sv
tb/tb_soc_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the soc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_soc_core

out=$(./obj_dir/Vtb_soc_core)
echo "$out"

# The run passes only if the testbench printed its pass line
echo "$out" | grep -qF '*** PASSED ***'

//--- tb/soc_core_tests.txt
# columns: op field_a field_b, fields in hex
# W adr data | R adr expect | P 0 0 pps | I run btn_lock | C pin expect | L count 0
I 5 0
C 1 1
C 2 3
C 0 0
C 3 0A
R 5C30 00090000
R 1000 0
W 7000 2
W 7010 1
W 72D0 0
W 72D4 0
C 0 2
C 1 0
C 2 0
W 72D4 1
C 2 2
L 8 0
I 5 0
W 7028 12345678
W 702C 10
R 5C28 12345678
P 0 0
R 5C38 12345678
I 5 5
R 5C34 A000
I 5 2
R 5C34 4000
W 7014 1
R 5C28 0
R 5C38 0
C 0 0
C 1 1
C 2 3
C 3 0A
W 7000 1
W 7010 1
W 72D0 0
W 7014 1
R 5C30 00090000
C 0 1
C 1 0
C 2 2
